/* ssb_sync_defs.svh */
`ifndef SSB_SYNC_DEFS_SVH
`define SSB_SYNC_DEFS_SVH

// ------------------------------
// ssb framing sizes
// ------------------------------

// samples per fft window
`define SSB_FFT_LEN 64

// cyclic prefix samples per symbol
`define SSB_CP_LEN 4

// ofdm symbols in one ssb
`define SSB_SYMS 4

// ------------------------------
// sample format
// ------------------------------

// width of one i or q component
`define SSB_IQ_DW 16

`endif

/* ssb_sync_pkg.sv */
`default_nettype none

`include "ssb_sync_defs.svh"

package ssb_sync_pkg;

    // complex baseband sample
    typedef struct packed {
        logic signed [`SSB_IQ_DW-1:0] re;
        logic signed [`SSB_IQ_DW-1:0] im;
    } iq_sample_t;

    // position of a sample inside the ssb
    typedef struct packed {
        logic [$clog2(`SSB_SYMS)-1:0]    sym_idx;
        logic                            in_cp;
        logic [$clog2(`SSB_FFT_LEN)-1:0] fft_idx;
    } ssb_pos_t;

    // tagged fft window sample
    typedef struct packed {
        iq_sample_t                      sample;
        logic [$clog2(`SSB_SYMS)-1:0]    sym_idx;
        logic [$clog2(`SSB_FFT_LEN)-1:0] fft_idx;
        logic                            last;
        logic [1:0]                      n_id_2;
    } ssb_beat_t;

    typedef enum logic {
        SYNC_SEARCH = 1'b0,
        SYNC_LOCKED = 1'b1
    } sync_state_t;

endpackage

`default_nettype wire

/* sync_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fsm (
    input  wire logic       clk_i,
    input  wire logic       reset_ni,
    input  wire logic       sample_valid_i,
    input  wire logic       pss_peak_i,
    input  wire logic [1:0] n_id_2_i,
    input  wire logic       ssb_done_i,
    output logic            locked_o,
    output logic [1:0]      n_id_2_o
);

    import ssb_sync_pkg::*;

    sync_state_t state_q;
    sync_state_t state_d;
    logic        peak_accept;
    logic [1:0]  n_id_2_q;

    // a peak only counts on a valid sample and while searching
    assign peak_accept = (state_q == SYNC_SEARCH) && sample_valid_i && pss_peak_i;

    // ------------------------------
    // state machine
    // ------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            SYNC_SEARCH: begin
                if (peak_accept) begin
                    state_d = SYNC_LOCKED;
                end
            end
            SYNC_LOCKED: begin
                // later peaks are ignored until the ssb is through
                if (ssb_done_i) begin
                    state_d = SYNC_SEARCH;
                end
            end
            default: begin
                state_d = SYNC_SEARCH;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= SYNC_SEARCH;
        end else begin
            state_q <= state_d;
        end
    end

    // n_id_2 held for the whole lock
    always_ff @(posedge clk_i) begin
        if (peak_accept) begin
            n_id_2_q <= n_id_2_i;
        end
    end

    assign locked_o = (state_q == SYNC_LOCKED);
    assign n_id_2_o = n_id_2_q;

    // ------------------------------
    // checks
    // ------------------------------

    // lock only follows a peak that came with a valid sample
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(locked_o) |-> $past(sample_valid_i && pss_peak_i));

    // end of ssb from the timer only while locked
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        ssb_done_i |-> state_q == SYNC_LOCKED);

endmodule

`default_nettype wire

/* symbol_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ssb_sync_defs.svh"

module symbol_timer (
    input  wire logic             clk_i,
    input  wire logic             reset_ni,
    input  wire logic             sample_valid_i,
    input  wire logic             locked_i,
    output ssb_sync_pkg::ssb_pos_t pos_o,
    output logic                  ssb_done_o
);

    localparam int SYM_LEN = `SSB_CP_LEN + `SSB_FFT_LEN;
    localparam int CNT_W   = $clog2(SYM_LEN);
    localparam int SYM_W   = $clog2(`SSB_SYMS);
    localparam int FFT_W   = $clog2(`SSB_FFT_LEN);

    logic [CNT_W-1:0] samp_cnt_q;
    logic [SYM_W-1:0] sym_cnt_q;
    logic             advance;
    logic             sym_last;

    assign advance  = locked_i && sample_valid_i;
    assign sym_last = (samp_cnt_q == CNT_W'(SYM_LEN - 1));

    // final window sample of the final symbol
    assign ssb_done_o = advance && sym_last && (sym_cnt_q == SYM_W'(`SSB_SYMS - 1));

    // ------------------------------
    // sample and symbol counters
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni || ssb_done_o) begin
            samp_cnt_q <= '0;
            sym_cnt_q  <= '0;
        end else if (advance) begin
            if (sym_last) begin
                samp_cnt_q <= '0;
                sym_cnt_q  <= sym_cnt_q + 1'b1;
            end else begin
                samp_cnt_q <= samp_cnt_q + 1'b1;
            end
        end
    end

    // prefix comes first, window index only meaningful after it
    assign pos_o.sym_idx = sym_cnt_q;
    assign pos_o.in_cp   = (samp_cnt_q < CNT_W'(`SSB_CP_LEN));
    assign pos_o.fft_idx = FFT_W'(samp_cnt_q - CNT_W'(`SSB_CP_LEN));

    // counter stays in range and rests at zero outside a lock
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (samp_cnt_q < CNT_W'(SYM_LEN)) && (locked_i || samp_cnt_q == '0));

endmodule

`default_nettype wire

/* cp_remover.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ssb_sync_defs.svh"

module cp_remover (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,
    input  wire ssb_sync_pkg::iq_sample_t sample_i,
    input  wire logic                    sample_valid_i,
    input  wire logic                    locked_i,
    input  wire ssb_sync_pkg::ssb_pos_t   pos_i,
    input  wire logic [1:0]              n_id_2_i,
    output ssb_sync_pkg::ssb_beat_t       beat_o,
    output logic                         beat_valid_o
);

    localparam int FFT_W = $clog2(`SSB_FFT_LEN);

    logic                      keep;
    logic [2*`SSB_IQ_DW-1:0]   sample_q;
    logic [$bits(pos_i.sym_idx)-1:0] sym_idx_q;
    logic [FFT_W-1:0]          fft_idx_q;
    logic [1:0]                n_id_2_q;
    logic                      last_q;
    logic                      valid_q;

    // window samples only, prefix dropped
    assign keep = sample_valid_i && locked_i && !pos_i.in_cp;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= keep;
            last_q  <= keep && (pos_i.fft_idx == FFT_W'(`SSB_FFT_LEN - 1));
        end
    end

    always_ff @(posedge clk_i) begin
        if (keep) begin
            sample_q  <= sample_i;
            sym_idx_q <= pos_i.sym_idx;
            fft_idx_q <= pos_i.fft_idx;
            n_id_2_q  <= n_id_2_i;
        end
    end

    assign beat_o = '{sample: sample_q, sym_idx: sym_idx_q, fft_idx: fft_idx_q,
                      last: last_q, n_id_2: n_id_2_q};
    assign beat_valid_o = valid_q;

    // last marks a real window sample taken during the lock
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        beat_o.last |-> beat_valid_o && $past(locked_i && !pos_i.in_cp));

endmodule

`default_nettype wire

/* ssb_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module ssb_sync (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,
    input  wire ssb_sync_pkg::iq_sample_t sample_i,
    input  wire logic                    sample_valid_i,
    input  wire logic                    pss_peak_i,
    input  wire logic [1:0]              n_id_2_i,
    output logic                         locked_o,
    output ssb_sync_pkg::ssb_beat_t       beat_o,
    output logic                         beat_valid_o
);

    import ssb_sync_pkg::*;

    logic       locked;
    logic [1:0] n_id_2;
    logic       ssb_done;
    ssb_pos_t   pos;

    // ------------------------------
    // lock control
    // ------------------------------

    sync_fsm u_sync_fsm (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .pss_peak_i     (pss_peak_i),
        .n_id_2_i       (n_id_2_i),
        .ssb_done_i     (ssb_done),
        .locked_o       (locked),
        .n_id_2_o       (n_id_2)
    );

    symbol_timer u_symbol_timer (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .locked_i       (locked),
        .pos_o          (pos),
        .ssb_done_o     (ssb_done)
    );

    // ------------------------------
    // output stage
    // ------------------------------

    cp_remover u_cp_remover (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .locked_i       (locked),
        .pos_i          (pos),
        .n_id_2_i       (n_id_2),
        .beat_o         (beat_o),
        .beat_valid_o   (beat_valid_o)
    );

    assign locked_o = locked;

endmodule

`default_nettype wire

/* tb_ssb_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ssb_sync_defs.svh"

module tb_ssb_sync;

    import ssb_sync_pkg::*;

    localparam int SYM_LEN      = `SSB_CP_LEN + `SSB_FFT_LEN;
    localparam int SSB_BEATS    = `SSB_SYMS * `SSB_FFT_LEN;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 200;
    localparam int NUM_SSB      = 6;
    localparam int NO_LIMIT     = 1 << 30;
    // one ssb at 75 % density plus its idle lead-in
    localparam int SSB_CYCLES   = (`SSB_SYMS * SYM_LEN * 4) / 3 + 8;
    localparam int PLAN_CYCLES  = RESET_CYCLES + IDLE_CYCLES + (NUM_SSB + 2) * SSB_CYCLES + 16;
    localparam int TIMEOUT_CYCLES = 4 * PLAN_CYCLES;

    logic       clk_i;
    logic       reset_ni;
    iq_sample_t sample_i;
    logic       sample_valid_i;
    logic       pss_peak_i;
    logic [1:0] n_id_2_i;
    logic       locked_o;
    ssb_beat_t  beat_o;
    logic       beat_valid_o;

    integer     seed;
    int         cycle_cnt = 0;

    // reference model state
    logic       m_locked;
    logic [1:0] m_nid;
    int         m_cnt;
    int         m_sym;
    logic       exp_valid;
    ssb_beat_t  exp_beat;
    logic       ssb_end;
    int         beat_cnt;
    int         ssb_cnt;

    ssb_sync u_ssb_sync (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .pss_peak_i     (pss_peak_i),
        .n_id_2_i       (n_id_2_i),
        .locked_o       (locked_o),
        .beat_o         (beat_o),
        .beat_valid_o   (beat_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    // ------------------------------
    // checks
    // ------------------------------

    task automatic stop_on_error();
        $display("Regression failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_beat(input ssb_beat_t exp, input ssb_beat_t act);
        if (act !== exp) begin
            $display("** Error at %0t: beat_o expected %h actual %h", $time, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_locked(input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: locked_o expected %b actual %b", $time, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_beat_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: beat_valid_o expected %b actual %b", $time, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_beat_count(input int exp, input int act);
        if (act != exp) begin
            $display("** Error at %0t: beat count expected %0d actual %0d", $time, exp, act);
            stop_on_error();
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------

    task automatic update_model();
        logic adv;
        logic done;
        int   win;
        ssb_end = 1'b0;
        if (!reset_ni) begin
            m_locked  = 1'b0;
            m_cnt     = 0;
            m_sym     = 0;
            exp_valid = 1'b0;
            beat_cnt  = 0;
        end else begin
            adv  = sample_valid_i && m_locked;
            win  = m_cnt - `SSB_CP_LEN;
            done = adv && (m_cnt == SYM_LEN - 1) && (m_sym == `SSB_SYMS - 1);
            exp_valid = adv && (m_cnt >= `SSB_CP_LEN);
            if (exp_valid) begin
                exp_beat.sample  = sample_i;
                exp_beat.sym_idx = 2'(m_sym);
                exp_beat.fft_idx = 6'(win);
                exp_beat.last    = (win == `SSB_FFT_LEN - 1);
                exp_beat.n_id_2  = m_nid;
            end
            if (!m_locked && sample_valid_i && pss_peak_i) begin
                m_locked = 1'b1;
                m_nid    = n_id_2_i;
                beat_cnt = 0;
            end else if (done) begin
                m_locked = 1'b0;
                ssb_end  = 1'b1;
            end
            if (done) begin
                m_cnt = 0;
                m_sym = 0;
            end else if (adv) begin
                m_cnt = (m_cnt == SYM_LEN - 1) ? 0 : m_cnt + 1;
                m_sym = (m_cnt == 0) ? m_sym + 1 : m_sym;
            end
        end
    endtask

    task automatic check_outputs();
        check_locked(m_locked, locked_o);
        check_beat_valid(exp_valid, beat_valid_o);
        if (exp_valid) begin
            check_beat(exp_beat, beat_o);
        end
        // beats seen on the dut output
        if (beat_valid_o === 1'b1) begin
            beat_cnt++;
        end
        if (ssb_end) begin
            check_beat_count(SSB_BEATS, beat_cnt);
            ssb_cnt++;
        end
    endtask

    // model at the edge, outputs settled 1 ns later, new inputs after that
    task automatic tick();
        @(posedge clk_i);
        update_model();
        #1;
        check_outputs();
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    task automatic drive_random(input bit allow_valid_peak);
        sample_valid_i = (($random(seed) & 3) != 0);
        sample_i       = $random(seed);
        pss_peak_i     = (($random(seed) & 15) == 0);
        if (!allow_valid_peak && sample_valid_i) begin
            pss_peak_i = 1'b0;
        end
        if (($random(seed) & 7) == 0) begin
            n_id_2_i = 2'($random(seed));
        end
    endtask

    // peaks only on gaps, none of them may lock
    task automatic drive_search_noise();
        sample_valid_i = (($random(seed) & 3) != 0);
        sample_i       = $random(seed);
        pss_peak_i     = !sample_valid_i && (($random(seed) & 1) != 0);
        n_id_2_i       = 2'($random(seed));
    endtask

    task automatic run_ssb(input int max_steps);
        int idle;
        int steps;
        idle = $random(seed) & 7;
        repeat (idle) begin
            tick();
            drive_random(1'b0);
        end
        tick();
        sample_valid_i = 1'b1;
        pss_peak_i     = 1'b1;
        n_id_2_i       = 2'($random(seed));
        sample_i       = $random(seed);
        steps = 0;
        do begin
            tick();
            drive_random(1'b1);
            // extra peak aimed at the final sample of the ssb
            if (m_locked && m_cnt == SYM_LEN - 1 && m_sym == `SSB_SYMS - 1) begin
                pss_peak_i = 1'b1;
            end
            steps++;
        end while (m_locked && steps < max_steps);
        pss_peak_i = 1'b0;
    endtask

    initial begin
        seed           = 32'h336e_36e1;
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        pss_peak_i     = 1'b0;
        n_id_2_i       = 2'b00;
        m_locked       = 1'b0;
        m_nid          = 2'b00;
        m_cnt          = 0;
        m_sym          = 0;
        exp_valid      = 1'b0;
        exp_beat       = '0;
        ssb_end        = 1'b0;
        beat_cnt       = 0;
        ssb_cnt        = 0;

        repeat (RESET_CYCLES) tick();
        reset_ni = 1'b1;

        repeat (IDLE_CYCLES) begin
            tick();
            drive_search_noise();
        end

        for (int k = 0; k < NUM_SSB; k++) begin
            run_ssb(NO_LIMIT);
        end

        // reset in the middle of a lock, then a clean relock
        run_ssb(100);
        reset_ni = 1'b0;
        repeat (3) begin
            tick();
            drive_random(1'b1);
        end
        reset_ni = 1'b1;
        run_ssb(NO_LIMIT);

        repeat (8) begin
            tick();
            sample_valid_i = 1'b0;
            pss_peak_i     = 1'b0;
        end

        if (ssb_cnt == NUM_SSB + 1) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("only %0d of %0d ssb completed", ssb_cnt, NUM_SSB + 1);
            $display("Regression failed");
            $fatal(1, "ssb count wrong");
        end
    end

endmodule

`default_nettype wire

/* ssb_sync.f */
+incdir+.
ssb_sync_pkg.sv
sync_fsm.sv
symbol_timer.sv
cp_remover.sv
ssb_sync.sv
tb_ssb_sync.sv

/* Bender.yml */
package:
  name: ssb_sync

sources:
  - include_dirs:
      - .
    files:
      - ssb_sync_pkg.sv
      - sync_fsm.sv
      - symbol_timer.sv
      - cp_remover.sv
      - ssb_sync.sv
      - target: test
        files:
          - tb_ssb_sync.sv
